// ==== verif/exec_stim.txt ====
// kind 1 instruction: kind op cond rs1 rs2 rd imm use_imm regwrite exp_written exp_data
// kind 2 final register: kind addr exp_value
1 a 0 00 00 01 12345678 1 1 1 12345678
1 a 0 00 00 02 0000000f 1 1 1 0000000f
1 a 0 00 00 03 fffffff0 1 1 1 fffffff0
1 0 0 01 02 04 00000000 0 1 1 12345687
1 1 0 04 02 05 00000000 0 1 1 12345678
1 2 0 01 00 06 0000ff00 1 1 1 00005600
1 3 0 03 02 07 00000000 0 1 1 ffffffff
1 4 0 01 00 08 ffffffff 1 1 1 edcba987
1 5 0 02 00 09 00000004 1 1 1 000000f0
1 6 0 03 00 0a 00000004 1 1 1 0fffffff
1 7 0 03 00 0b 00000004 1 1 1 ffffffff
1 8 0 03 02 0c 00000000 0 1 1 00000001
1 9 0 03 02 0d 00000000 0 1 1 00000000
1 0 0 09 00 0e 00000010 1 1 1 00000100
1 0 0 0e 0e 0f 00000000 0 1 1 00000200
1 0 0 0f 0e 10 00000000 0 1 1 00000300
1 1 0 10 0f 11 00000000 0 1 1 00000100
1 0 1 02 02 12 00000055 1 1 1 00000064
1 a 1 01 02 12 0000dead 1 1 0 0000dead
1 0 0 12 00 13 00000000 1 1 1 00000064
1 a 2 01 02 14 0000beef 1 1 1 0000beef
1 a 2 02 02 14 00001111 1 1 0 00001111
1 a 3 03 02 15 00002222 1 1 1 00002222
1 a 3 02 03 15 00003333 1 1 0 00003333
1 4 0 14 15 16 00000000 0 1 1 00009ccd
1 a 0 00 00 17 00009ccd 1 1 1 00009ccd
1 0 1 17 16 18 00000001 1 1 1 00009cce
1 a 0 00 00 00 0000abcd 1 1 0 0000abcd
1 3 0 00 01 19 00000000 0 1 1 12345678
1 0 0 01 00 1a 00000001 1 0 0 12345679
1 1 0 00 01 1a 00000000 0 1 1 edcba988
1 8 0 1a 01 1b 00000000 0 1 1 00000001
2 00 00000000
2 04 12345687
2 08 edcba987
2 10 00000300
2 11 00000100
2 12 00000064
2 14 0000beef
2 15 00002222
2 18 00009cce
2 1a edcba988
2 1b 00000001
2 1c 00000000

// ==== files.f ====
design/exec_pkg.sv
design/alu_unit.sv
design/operand_forward.sv
design/execute_stage.sv
design/issue_stage.sv
design/writeback_regfile.sv
design/exec_top.sv
verif/exec_properties.sv
verif/exec_tb.sv

// ==== Makefile ====
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= exec_tb
FILELIST ?= files.f
OBJ_DIR  ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulation is the pass or fail result
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/exec_tb.sv ====
`timescale 1ns/10ps

module exec_tb import exec_pkg::*;
();

  localparam int clk_half    = 20;
  localparam int drive_delay = 2;
  localparam int stim_aw     = 9;
  localparam int instr_words = 11;
  localparam int final_words = 3;
  localparam int accept_wait = 64;
  localparam int drain_wait  = 256;

  logic      clk;
  logic      rst_n;
  logic      in_valid;
  alu_op_e   in_op;
  cond_e     in_cond;
  reg_addr_t in_rs1;
  reg_addr_t in_rs2;
  reg_addr_t in_rd;
  data_t     in_imm;
  logic      in_use_imm;
  logic      in_regwrite;
  logic      hold;
  reg_addr_t dbg_addr;
  logic      in_ready;
  logic      res_valid;
  reg_addr_t res_rd;
  data_t     res_data;
  logic      res_written;
  data_t     dbg_data;

  // Raw stim words and record start offsets
  data_t       stim_mem [2**stim_aw];
  int          instr_idx_q [$];
  int          fin_idx_q [$];
  // Expected results in program order
  reg_addr_t   exp_rd_q [$];
  data_t       exp_data_q [$];
  logic        exp_wr_q [$];
  logic [31:0] rnd_state;

  exec_top uut
  (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_op       (in_op),
    .in_cond     (in_cond),
    .in_rs1      (in_rs1),
    .in_rs2      (in_rs2),
    .in_rd       (in_rd),
    .in_imm      (in_imm),
    .in_use_imm  (in_use_imm),
    .in_regwrite (in_regwrite),
    .hold        (hold),
    .dbg_addr    (dbg_addr),
    .in_ready    (in_ready),
    .res_valid   (res_valid),
    .res_rd      (res_rd),
    .res_data    (res_data),
    .res_written (res_written),
    .dbg_data    (dbg_data)
  );

  bind execute_stage exec_properties u_props
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .hold      (hold),
    .iss_valid (iss_valid),
    .ex_valid  (ex_valid),
    .ex_we     (ex_we),
    .ex_rd     (ex_rd),
    .ex_data   (ex_data)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #(clk_half) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped at first failure");
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp)
      abort_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp)
      abort_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
  endtask

  // 32-bit xorshift step
  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Hold in roughly one cycle of four
  task automatic update_hold();
    rnd_state = next_random(rnd_state);
    hold      = (rnd_state[1:0] == 2'b00);
  endtask

  function automatic data_t stim_at(input int pos);
    logic [stim_aw-1:0] a;
    a = pos[stim_aw-1:0];
    return stim_mem[a];
  endfunction

  // Split the stim words into records
  task automatic load_stim();
    int    idx;
    logic  done;
    data_t w;
    $readmemh("verif/exec_stim.txt", stim_mem);
    idx  = 0;
    done = 1'b0;
    while (!done && (idx < 2**stim_aw - instr_words))
    begin
      case (stim_at(idx))
        32'h1:
        begin
          instr_idx_q.push_back(idx);
          w = stim_at(idx + 5);
          exp_rd_q.push_back(w[reg_addr_w-1:0]);
          w = stim_at(idx + 9);
          exp_wr_q.push_back(w[0]);
          exp_data_q.push_back(stim_at(idx + 10));
          idx += instr_words;
        end
        32'h2:
        begin
          fin_idx_q.push_back(idx);
          idx += final_words;
        end
        default:
          done = 1'b1;
      endcase
    end
    if (instr_idx_q.size() == 0)
      abort_run("Stim file holds no instruction records");
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Present one record until an unheld edge takes it
  task automatic issue_instr(input int base);
    logic  accepted;
    int    waited;
    data_t w;
    accepted    = 1'b0;
    waited      = 0;
    in_valid    = 1'b1;
    w           = stim_at(base + 1);
    in_op       = alu_op_e'(w[3:0]);
    w           = stim_at(base + 2);
    in_cond     = cond_e'(w[1:0]);
    w           = stim_at(base + 3);
    in_rs1      = w[reg_addr_w-1:0];
    w           = stim_at(base + 4);
    in_rs2      = w[reg_addr_w-1:0];
    w           = stim_at(base + 5);
    in_rd       = w[reg_addr_w-1:0];
    in_imm      = stim_at(base + 6);
    w           = stim_at(base + 7);
    in_use_imm  = w[0];
    w           = stim_at(base + 8);
    in_regwrite = w[0];
    while (!accepted)
    begin
      @(posedge clk);
      // Ready is the inverse of hold
      check_flag("in_ready", in_ready, !hold);
      accepted = !hold;
      #(drive_delay);
      update_hold();
      if (!accepted)
      begin
        waited++;
        if (waited > accept_wait)
          abort_run("Timeout: instruction never accepted, in_ready stayed low");
      end
    end
  endtask

  // Random hold keeps running while results retire
  task automatic drain_pipeline();
    int waited;
    waited = 0;
    while (exp_rd_q.size() != 0)
    begin
      @(posedge clk);
      #(drive_delay);
      update_hold();
      waited++;
      if (waited > drain_wait)
        abort_run($sformatf("Timeout: %0d results never retired", exp_rd_q.size()));
    end
    hold = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Checking
  //////////////////////////////////////////////////

  task automatic score_result();
    reg_addr_t rd;
    data_t     data;
    logic      wr;
    if (exp_rd_q.size() == 0)
      abort_run("Result reported with no instruction outstanding");
    rd   = exp_rd_q.pop_front();
    data = exp_data_q.pop_front();
    wr   = exp_wr_q.pop_front();
    check_addr("res_rd", res_rd, rd);
    check_flag("res_written", res_written, wr);
    check_data("res_data", res_data, data);
  endtask

  task automatic verify_final_regs();
    data_t w;
    foreach (fin_idx_q[i])
    begin
      @(posedge clk);
      #(drive_delay);
      w        = stim_at(fin_idx_q[i] + 1);
      dbg_addr = w[reg_addr_w-1:0];
      @(negedge clk);
      check_data($sformatf("dbg_data[x%0d]", dbg_addr), dbg_data, stim_at(fin_idx_q[i] + 2));
    end
  endtask

  // Count a result only after an unheld edge
  initial
  begin
    logic edge_hold;
    forever
    begin
      @(posedge clk);
      edge_hold = hold;
      @(negedge clk);
      if (rst_n && !edge_hold && res_valid)
        score_result();
    end
  end

  initial
  begin
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    in_op       = op_add;
    in_cond     = cond_always;
    in_rs1      = '0;
    in_rs2      = '0;
    in_rd       = '0;
    in_imm      = '0;
    in_use_imm  = 1'b0;
    in_regwrite = 1'b0;
    hold        = 1'b0;
    dbg_addr    = '0;
    rnd_state   = 32'd1099;
    load_stim();
    repeat (5) @(posedge clk);
    #(drive_delay);
    rst_n = 1'b1;
    foreach (instr_idx_q[i])
      issue_instr(instr_idx_q[i]);
    in_valid = 1'b0;
    drain_pipeline();
    // Idle edges expose any duplicated result
    repeat (4) @(posedge clk);
    verify_final_regs();
    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== verif/exec_properties.sv ====
`timescale 1ns/10ps

module exec_properties import exec_pkg::*;
(
  input logic      clk,
  input logic      rst_n,
  input logic      hold,
  input logic      iss_valid,
  input logic      ex_valid,
  input logic      ex_we,
  input reg_addr_t ex_rd,
  input data_t     ex_data
);

  //////////////////////////////////////////////////
  // Hold behavior
  //////////////////////////////////////////////////

  // Control flops frozen for one held edge
  property hold_keeps_ctrl;
    @(posedge clk) disable iff (!rst_n)
      hold |=> $stable(ex_valid) && $stable(ex_we);
  endproperty

  // Payload frozen too, once it carries an instruction
  property hold_keeps_payload;
    @(posedge clk) disable iff (!rst_n)
      (hold && ex_valid) |=> $stable(ex_rd) && $stable(ex_data);
  endproperty

  //////////////////////////////////////////////////
  // Write enable and reset
  //////////////////////////////////////////////////

  // Write only for a live instruction, never x0
  property we_needs_valid_rd;
    @(posedge clk) disable iff (!rst_n)
      ex_we |-> ex_valid && (ex_rd != '0);
  endproperty

  // Valid flags cleared while reset is low
  property reset_clears_valid;
    @(posedge clk)
      !rst_n |-> !iss_valid && !ex_valid && !ex_we;
  endproperty

  a_hold_ctrl:    assert property (hold_keeps_ctrl)
    else $error("Execute control changed during hold");
  a_hold_payload: assert property (hold_keeps_payload)
    else $error("Execute payload changed during hold");
  a_we_valid:     assert property (we_needs_valid_rd)
    else $error("ex_we without valid instruction or with rd zero");
  a_reset_valid:  assert property (reset_clears_valid)
    else $error("Valid flag high during reset");

endmodule

// ==== design/exec_top.sv ====
`timescale 1ns/10ps

module exec_top import exec_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      in_valid,
  input  alu_op_e   in_op,
  input  cond_e     in_cond,
  input  reg_addr_t in_rs1,
  input  reg_addr_t in_rs2,
  input  reg_addr_t in_rd,
  input  data_t     in_imm,
  input  logic      in_use_imm,
  input  logic      in_regwrite,
  input  logic      hold,
  input  reg_addr_t dbg_addr,
  output logic      in_ready,
  output logic      res_valid,
  output reg_addr_t res_rd,
  output data_t     res_data,
  output logic      res_written,
  output data_t     dbg_data
);

  // Register file read port
  reg_addr_t rf_rs1_addr;
  reg_addr_t rf_rs2_addr;
  data_t     rf_rs1_data;
  data_t     rf_rs2_data;
  // Issue register
  logic      iss_valid;
  alu_op_e   iss_op;
  cond_e     iss_cond;
  reg_addr_t iss_rs1;
  reg_addr_t iss_rs2;
  reg_addr_t iss_rd;
  data_t     iss_imm;
  logic      iss_use_imm;
  logic      iss_regwrite;
  data_t     iss_rs1_data;
  data_t     iss_rs2_data;
  // Execute register, also the file write port
  logic      ex_valid;
  logic      ex_we;
  reg_addr_t ex_rd;
  data_t     ex_data;
  // Last write for forwarding
  logic      wb_we;
  reg_addr_t wb_rd;
  data_t     wb_data;

  //////////////////////////////////////////////////
  // Stages
  //////////////////////////////////////////////////

  // Issue bypass sees the write landing on the same edge
  issue_stage u_issue
  (
    .clk          (clk),
    .rst_n        (rst_n),
    .hold         (hold),
    .in_valid     (in_valid),
    .in_op        (in_op),
    .in_cond      (in_cond),
    .in_rs1       (in_rs1),
    .in_rs2       (in_rs2),
    .in_rd        (in_rd),
    .in_imm       (in_imm),
    .in_use_imm   (in_use_imm),
    .in_regwrite  (in_regwrite),
    .rf_rs1_data  (rf_rs1_data),
    .rf_rs2_data  (rf_rs2_data),
    .wb_we        (ex_we),
    .wb_rd        (ex_rd),
    .wb_data      (ex_data),
    .in_ready     (in_ready),
    .rf_rs1_addr  (rf_rs1_addr),
    .rf_rs2_addr  (rf_rs2_addr),
    .iss_valid    (iss_valid),
    .iss_op       (iss_op),
    .iss_cond     (iss_cond),
    .iss_rs1      (iss_rs1),
    .iss_rs2      (iss_rs2),
    .iss_rd       (iss_rd),
    .iss_imm      (iss_imm),
    .iss_use_imm  (iss_use_imm),
    .iss_regwrite (iss_regwrite),
    .iss_rs1_data (iss_rs1_data),
    .iss_rs2_data (iss_rs2_data)
  );

  execute_stage u_execute
  (
    .clk          (clk),
    .rst_n        (rst_n),
    .hold         (hold),
    .iss_valid    (iss_valid),
    .iss_op       (iss_op),
    .iss_cond     (iss_cond),
    .iss_rs1      (iss_rs1),
    .iss_rs2      (iss_rs2),
    .iss_rd       (iss_rd),
    .iss_imm      (iss_imm),
    .iss_use_imm  (iss_use_imm),
    .iss_regwrite (iss_regwrite),
    .iss_rs1_data (iss_rs1_data),
    .iss_rs2_data (iss_rs2_data),
    .wb_we        (wb_we),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .ex_valid     (ex_valid),
    .ex_we        (ex_we),
    .ex_rd        (ex_rd),
    .ex_data      (ex_data)
  );

  writeback_regfile u_writeback
  (
    .clk          (clk),
    .rst_n        (rst_n),
    .hold         (hold),
    .ex_valid     (ex_valid),
    .ex_we        (ex_we),
    .ex_rd        (ex_rd),
    .ex_data      (ex_data),
    .rf_rs1_addr  (rf_rs1_addr),
    .rf_rs2_addr  (rf_rs2_addr),
    .dbg_addr     (dbg_addr),
    .rf_rs1_data  (rf_rs1_data),
    .rf_rs2_data  (rf_rs2_data),
    .dbg_data     (dbg_data),
    .wb_we        (wb_we),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .res_valid    (res_valid),
    .res_rd       (res_rd),
    .res_data     (res_data),
    .res_written  (res_written)
  );

endmodule

// ==== design/writeback_regfile.sv ====
`timescale 1ns/10ps

module writeback_regfile import exec_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      hold,
  input  logic      ex_valid,
  input  logic      ex_we,
  input  reg_addr_t ex_rd,
  input  data_t     ex_data,
  input  reg_addr_t rf_rs1_addr,
  input  reg_addr_t rf_rs2_addr,
  input  reg_addr_t dbg_addr,
  output data_t     rf_rs1_data,
  output data_t     rf_rs2_data,
  output data_t     dbg_data,
  output logic      wb_we,
  output reg_addr_t wb_rd,
  output data_t     wb_data,
  output logic      res_valid,
  output reg_addr_t res_rd,
  output data_t     res_data,
  output logic      res_written
);

  // Register storage, x0 stays zero
  data_t regs [num_regs];

  //////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < num_regs; i++)
        regs[i] <= '0;
    end
    else if (ex_we && !hold && (ex_rd != '0))
    begin
      regs[ex_rd] <= ex_data;
    end
  end

  // Combinational read ports
  assign rf_rs1_data = regs[rf_rs1_addr];
  assign rf_rs2_data = regs[rf_rs2_addr];
  assign dbg_data    = regs[dbg_addr];

  //////////////////////////////////////////////////
  // Retire and last-write registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_we       <= 1'b0;
      res_valid   <= 1'b0;
      res_rd      <= '0;
      res_data    <= '0;
      res_written <= 1'b0;
    end
    else if (!hold)
    begin
      wb_we       <= ex_we;
      res_valid   <= ex_valid;
      res_rd      <= ex_rd;
      res_data    <= ex_data;
      res_written <= ex_we;
    end
  end

  // Forwarding copy of the last write
  always_ff @(posedge clk)
  begin
    if (!hold)
    begin
      wb_rd   <= ex_rd;
      wb_data <= ex_data;
    end
  end

endmodule

// ==== design/issue_stage.sv ====
`timescale 1ns/10ps

module issue_stage import exec_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      hold,
  input  logic      in_valid,
  input  alu_op_e   in_op,
  input  cond_e     in_cond,
  input  reg_addr_t in_rs1,
  input  reg_addr_t in_rs2,
  input  reg_addr_t in_rd,
  input  data_t     in_imm,
  input  logic      in_use_imm,
  input  logic      in_regwrite,
  input  data_t     rf_rs1_data,
  input  data_t     rf_rs2_data,
  input  logic      wb_we,
  input  reg_addr_t wb_rd,
  input  data_t     wb_data,
  output logic      in_ready,
  output reg_addr_t rf_rs1_addr,
  output reg_addr_t rf_rs2_addr,
  output logic      iss_valid,
  output alu_op_e   iss_op,
  output cond_e     iss_cond,
  output reg_addr_t iss_rs1,
  output reg_addr_t iss_rs2,
  output reg_addr_t iss_rd,
  output data_t     iss_imm,
  output logic      iss_use_imm,
  output logic      iss_regwrite,
  output data_t     iss_rs1_data,
  output data_t     iss_rs2_data
);

  logic  accept;
  // Operands after same-edge write bypass
  data_t rs1_val;
  data_t rs2_val;

  assign in_ready    = !hold;
  assign accept      = in_valid && in_ready;
  // Read addresses straight from the incoming instruction
  assign rf_rs1_addr = in_rs1;
  assign rf_rs2_addr = in_rs2;

  // Write on this edge wins over the stale file value
  assign rs1_val = (wb_we && (wb_rd == in_rs1) && (in_rs1 != '0)) ? wb_data : rf_rs1_data;
  assign rs2_val = (wb_we && (wb_rd == in_rs2) && (in_rs2 != '0)) ? wb_data : rf_rs2_data;

  //////////////////////////////////////////////////
  // Issue register
  //////////////////////////////////////////////////

  // Empty slot clears valid
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      iss_valid <= 1'b0;
    else if (!hold)
      iss_valid <= in_valid;
  end

  // Fields loaded only on acceptance
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      iss_op       <= in_op;
      iss_cond     <= in_cond;
      iss_rs1      <= in_rs1;
      iss_rs2      <= in_rs2;
      iss_rd       <= in_rd;
      iss_imm      <= in_imm;
      iss_use_imm  <= in_use_imm;
      iss_regwrite <= in_regwrite;
      iss_rs1_data <= rs1_val;
      iss_rs2_data <= rs2_val;
    end
  end

endmodule

// ==== design/execute_stage.sv ====
`timescale 1ns/10ps

module execute_stage import exec_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      hold,
  input  logic      iss_valid,
  input  alu_op_e   iss_op,
  input  cond_e     iss_cond,
  input  reg_addr_t iss_rs1,
  input  reg_addr_t iss_rs2,
  input  reg_addr_t iss_rd,
  input  data_t     iss_imm,
  input  logic      iss_use_imm,
  input  logic      iss_regwrite,
  input  data_t     iss_rs1_data,
  input  data_t     iss_rs2_data,
  input  logic      wb_we,
  input  reg_addr_t wb_rd,
  input  data_t     wb_data,
  output logic      ex_valid,
  output logic      ex_we,
  output reg_addr_t ex_rd,
  output data_t     ex_data
);

  // Forwarded operands
  data_t fw_rs1;
  data_t fw_rs2;
  data_t alu_b;
  // ALU outputs
  data_t alu_result;
  logic  cond_true;
  // Write enable for the instruction in issue
  logic  next_we;

  operand_forward u_forward
  (
    .iss_rs1      (iss_rs1),
    .iss_rs2      (iss_rs2),
    .iss_rs1_data (iss_rs1_data),
    .iss_rs2_data (iss_rs2_data),
    .iss_imm      (iss_imm),
    .iss_use_imm  (iss_use_imm),
    .ex_we        (ex_we),
    .ex_rd        (ex_rd),
    .ex_data      (ex_data),
    .wb_we        (wb_we),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .fw_rs1       (fw_rs1),
    .fw_rs2       (fw_rs2),
    .alu_b        (alu_b)
  );

  alu_unit u_alu
  (
    .a         (fw_rs1),
    .b         (alu_b),
    .cmp_a     (fw_rs1),
    .cmp_b     (fw_rs2),
    .op        (iss_op),
    .cond      (iss_cond),
    .result    (alu_result),
    .cond_true (cond_true)
  );

  //////////////////////////////////////////////////
  // Execute register
  //////////////////////////////////////////////////

  // Compare-gated write, x0 filtered here
  assign next_we = iss_valid && iss_regwrite && cond_true && (iss_rd != '0);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ex_valid <= 1'b0;
      ex_we    <= 1'b0;
    end
    else if (!hold)
    begin
      ex_valid <= iss_valid;
      ex_we    <= next_we;
    end
  end

  // Payload follows the control flops
  always_ff @(posedge clk)
  begin
    if (!hold)
    begin
      ex_rd   <= iss_rd;
      ex_data <= alu_result;
    end
  end

endmodule

// ==== design/operand_forward.sv ====
`timescale 1ns/10ps

module operand_forward import exec_pkg::*;
(
  input  reg_addr_t iss_rs1,
  input  reg_addr_t iss_rs2,
  input  data_t     iss_rs1_data,
  input  data_t     iss_rs2_data,
  input  data_t     iss_imm,
  input  logic      iss_use_imm,
  input  logic      ex_we,
  input  reg_addr_t ex_rd,
  input  data_t     ex_data,
  input  logic      wb_we,
  input  reg_addr_t wb_rd,
  input  data_t     wb_data,
  output data_t     fw_rs1,
  output data_t     fw_rs2,
  output data_t     alu_b
);

  // Hit flags per source and per younger destination
  logic ex_hit_rs1;
  logic ex_hit_rs2;
  logic wb_hit_rs1;
  logic wb_hit_rs2;

  //////////////////////////////////////////////////
  // Hazard detection
  //////////////////////////////////////////////////

  // x0 never matches
  assign ex_hit_rs1 = ex_we && (ex_rd == iss_rs1) && (iss_rs1 != '0);
  assign ex_hit_rs2 = ex_we && (ex_rd == iss_rs2) && (iss_rs2 != '0);
  assign wb_hit_rs1 = wb_we && (wb_rd == iss_rs1) && (iss_rs1 != '0);
  assign wb_hit_rs2 = wb_we && (wb_rd == iss_rs2) && (iss_rs2 != '0);

  //////////////////////////////////////////////////
  // Operand select
  //////////////////////////////////////////////////

  // Newest value first, then last write, then issue copy
  assign fw_rs1 = ex_hit_rs1 ? ex_data :
                  wb_hit_rs1 ? wb_data :
                               iss_rs1_data;

  assign fw_rs2 = ex_hit_rs2 ? ex_data :
                  wb_hit_rs2 ? wb_data :
                               iss_rs2_data;

  // Second ALU operand
  assign alu_b = iss_use_imm ? iss_imm : fw_rs2;

endmodule

// ==== design/alu_unit.sv ====
`timescale 1ns/10ps

module alu_unit import exec_pkg::*;
(
  input  data_t   a,
  input  data_t   b,
  input  data_t   cmp_a,
  input  data_t   cmp_b,
  input  alu_op_e op,
  input  cond_e   cond,
  output data_t   result,
  output logic    cond_true
);

  // Shift amount
  logic [shamt_w-1:0] shamt;
  // Compare flags for set-less-than
  logic               lt_signed;
  logic               lt_unsigned;

  assign shamt       = b[shamt_w-1:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  //////////////////////////////////////////////////
  // Result mux
  //////////////////////////////////////////////////

  always_comb
  begin
    result = '0;
    case (op)
      op_add:  result = a + b;
      op_sub:  result = a - b;
      op_and:  result = a & b;
      op_or:   result = a | b;
      op_xor:  result = a ^ b;
      op_sll:  result = a << shamt;
      op_srl:  result = a >> shamt;
      // Arithmetic shift keeps the sign bit
      op_sra:  result = data_t'($signed(a) >>> shamt);
      op_slt:  result[0] = lt_signed;
      op_sltu: result[0] = lt_unsigned;
      // Immediate arrives on b
      op_lui:  result = b;
      default: result = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Write condition
  //////////////////////////////////////////////////

  // Register operands only, immediate never involved
  always_comb
  begin
    cond_true = 1'b1;
    case (cond)
      cond_always: cond_true = 1'b1;
      cond_eq:     cond_true = (cmp_a == cmp_b);
      cond_ne:     cond_true = (cmp_a != cmp_b);
      // Signed less-than
      cond_lt:     cond_true = ($signed(cmp_a) < $signed(cmp_b));
      default:     cond_true = 1'b1;
    endcase
  end

endmodule

// ==== design/exec_pkg.sv ====
package exec_pkg;

  //////////////////////////////////////////////////
  // Widths and sizes
  //////////////////////////////////////////////////

  // Data word width
  localparam int data_w = 32;
  // Register address width
  localparam int reg_addr_w = 5;
  // Register count, x0 hardwired to zero
  localparam int num_regs = 32;
  // Shift amount taken from low bits of operand b
  localparam int shamt_w = $clog2(data_w);

  typedef logic [data_w-1:0]     data_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  //////////////////////////////////////////////////
  // Opcodes and write conditions
  //////////////////////////////////////////////////

  // ALU operations
  typedef enum logic [3:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_sll,
    op_srl,
    op_sra,
    op_slt,
    op_sltu,
    op_lui
  } alu_op_e;

  // Condition gating the register write
  typedef enum logic [1:0] {
    cond_always,
    cond_eq,
    cond_ne,
    cond_lt
  } cond_e;

endpackage
